// ==== dma_defines.svh ====
// DMA controller constants
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// channel count, channel 0 has the highest priority
`define DMA_CHANNELS 4

// display counter values that trigger blank starts
`define HBLANK_LINE 240
`define VBLANK_LINE 160

// video capture window on channel 3
`define CAPTURE_FIRST 2
`define CAPTURE_LAST 162

// fixed capture destination
`define CAPTURE_BASE 32'h0600_0000

`endif

// ==== dma_pkg.sv ====
// DMA controller types
package dma_pkg;

  // controlHi[13:12]
  typedef enum logic [1:0] {
    IMMEDIATE = 2'b00,
    HBLANK    = 2'b01,
    VBLANK    = 2'b10,
    SPECIAL   = 2'b11
  } startTiming_t;

  // controlHi[8:7] for the source, controlHi[6:5] for the destination
  typedef enum logic [1:0] {
    INC       = 2'b00,
    DEC       = 2'b01,
    FIXED     = 2'b10,
    INCRELOAD = 2'b11
  } addrStep_t;

  typedef enum logic [2:0] {
    OFF,
    IDLE,
    QUEUED,
    READ,
    WRITE,
    PREEMPTEDREAD,
    PREEMPTEDWRITE
  } seqState_t;

  // msb marks a valid size, lsb selects word
  typedef enum logic [1:0] {
    HALF = 2'b10,
    WORD = 2'b11
  } busSize_t;

endpackage

// ==== dmaStartTrigger.sv ====
// DMA start condition
`timescale 1ns/1ns
`include "dma_defines.svh"

module dmaStartTrigger #(
  parameter int chanId = 0
) (
  input  logic        clk,
  input  logic        rst_b,
  input  logic [15:0] controlHi,
  input  logic [15:0] vcount,
  input  logic [15:0] hcount,
  input  logic        soundReq,
  output logic        start,
  output logic        captureStop
);
  import dma_pkg::*;

  startTiming_t timing;
  logic captureMode;
  logic atLast;
  logic inWindow;
  logic armed;     // capture allowed for the coming frame
  logic lastLineQ; // previous cycle was on the stop line

  assign timing = startTiming_t'(controlHi[13:12]);
  assign captureMode = (chanId == 3) && (timing == SPECIAL);
  assign atLast = (vcount[7:0] == 8'(`CAPTURE_LAST));
  assign inWindow = (vcount[7:0] >= 8'(`CAPTURE_FIRST)) && (vcount[7:0] < 8'(`CAPTURE_LAST));

  // one pulse on entering the stop line
  assign captureStop = captureMode && controlHi[15] && atLast && !lastLineQ;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      armed <= 1'b0;
      lastLineQ <= 1'b0;
    end else begin
      lastLineQ <= atLast;
      if (captureStop) begin
        armed <= 1'b1;
      end else if (!captureMode) begin
        armed <= 1'b0; // leaving capture mode drops the arming
      end
    end
  end

  always_comb begin
    case (timing)
      IMMEDIATE: start = 1'b1;
      HBLANK:    start = (hcount[7:0] == 8'(`HBLANK_LINE));
      VBLANK:    start = (vcount[7:0] == 8'(`VBLANK_LINE));
      default: begin
        if (chanId == 1 || chanId == 2) begin
          start = soundReq; // sound FIFO request
        end else if (chanId == 3) begin
          start = armed && inWindow;
        end else begin
          start = 1'b0;
        end
      end
    endcase
  end

endmodule

// ==== dmaSequencer.sv ====
// DMA channel sequencer
`timescale 1ns/1ns

module dmaSequencer (
  input  logic        clk,
  input  logic        rst_b,
  input  logic [15:0] controlHi,
  input  logic        start,
  input  logic        memWait,
  input  logic        preempted,
  input  logic        xferDone,
  output logic        loadCnt,
  output logic        loadSad,
  output logic        loadDad,
  output logic        stepSrc,
  output logic        stepDest,
  output logic        storeRData,
  output logic        busy,
  output logic        onBus,
  output logic        writing,
  output logic        irq,
  output logic        disableDma
);
  import dma_pkg::*;

  seqState_t state;
  seqState_t nextState;
  logic enable;
  logic repeatOn;
  logic canRun; // bus free for this channel

  assign enable = controlHi[15];
  assign repeatOn = controlHi[9];
  assign canRun = !preempted && !memWait;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= OFF;
    end else begin
      state <= nextState;
    end
  end

  // bus ownership straight from the state register
  assign onBus = (state == READ) || (state == WRITE);
  assign writing = (state == WRITE);
  assign busy = !(state inside {OFF, IDLE}) || ((state == IDLE) && start);

  always_comb begin
    nextState = state;
    loadCnt = 1'b0;
    loadSad = 1'b0;
    loadDad = 1'b0;
    stepSrc = 1'b0;
    stepDest = 1'b0;
    storeRData = 1'b0;
    irq = 1'b0;
    disableDma = 1'b0;
    case (state)
      OFF: begin
        if (enable) begin
          loadCnt = 1'b1;
          loadSad = 1'b1;
          loadDad = 1'b1;
          nextState = IDLE;
        end
      end
      IDLE: begin
        if (!enable) begin
          nextState = OFF;
        end else if (start) begin
          nextState = canRun ? READ : QUEUED;
        end
      end
      QUEUED, PREEMPTEDREAD: begin
        if (!enable) begin
          nextState = OFF;
        end else if (canRun) begin
          nextState = READ;
        end
      end
      PREEMPTEDWRITE: begin
        if (!enable) begin
          nextState = OFF;
        end else if (canRun) begin
          nextState = WRITE;
        end
      end
      READ: begin
        if (!memWait) begin
          stepSrc = 1'b1;
          storeRData = 1'b1;
          nextState = preempted ? PREEMPTEDWRITE : WRITE;
        end
      end
      WRITE: begin
        if (!memWait) begin
          if (xferDone) begin
            irq = controlHi[14];
            if (repeatOn) begin
              loadCnt = 1'b1;
              nextState = IDLE;
            end else begin
              disableDma = 1'b1; // host clears the enable bit
              nextState = OFF;
            end
          end else if (!enable) begin
            nextState = OFF;
          end else begin
            stepDest = 1'b1;
            nextState = preempted ? PREEMPTEDREAD : READ;
          end
        end
      end
      default: nextState = OFF;
    endcase
  end

endmodule

// ==== dmaAddressPath.sv ====
// DMA channel address and data path
`timescale 1ns/1ns
`include "dma_defines.svh"

module dmaAddressPath #(
  parameter int chanId = 0
) (
  input  logic        clk,
  input  logic        rst_b,
  input  logic [15:0] controlLo,
  input  logic [15:0] controlHi,
  input  logic [31:0] srcAddr,
  input  logic [31:0] destAddr,
  input  logic [31:0] rdata,
  input  logic        loadCnt,
  input  logic        loadSad,
  input  logic        loadDad,
  input  logic        stepSrc,
  input  logic        stepDest,
  input  logic        storeRData,
  input  logic        writing,
  output logic [31:0] chanAddr,
  output logic [31:0] chanData,
  output logic        xferDone
);
  import dma_pkg::*;

  localparam bit srcGamePak = (chanId != 0);
  localparam bit destGamePak = (chanId == 3);
  localparam bit soundChan = (chanId == 1) || (chanId == 2);
  localparam bit captureChan = (chanId == 3);

  startTiming_t timing;
  addrStep_t srcMode;
  addrStep_t destMode;
  logic [27:0] srcReg;
  logic [27:0] destReg;
  logic [27:0] srcNext;
  logic [27:0] destNext;
  logic [27:0] stepSize;
  logic [31:0] destTarget;
  logic [13:0] wordCnt;
  logic destReload;

  // bit 27 is the game-pak region
  function automatic logic [27:0] cutAddr(input logic [27:0] a, input bit keepPak);
    cutAddr = {keepPak & a[27], a[26:0]};
  endfunction

  function automatic logic [27:0] stepAddr(input logic [27:0] a, input addrStep_t mode,
                                           input logic [27:0] step);
    case (mode)
      DEC:     stepAddr = a - step;
      FIXED:   stepAddr = a;
      default: stepAddr = a + step; // INC and INCRELOAD
    endcase
  endfunction

  always_comb begin
    timing = startTiming_t'(controlHi[13:12]);
    srcMode = addrStep_t'(controlHi[8:7]);
    destMode = addrStep_t'(controlHi[6:5]);
    destTarget = destAddr;
    if (timing == SPECIAL) begin
      if (soundChan) begin
        destMode = FIXED; // sound FIFO port
      end
      if (captureChan) begin
        destTarget = `CAPTURE_BASE;
      end
    end
  end

  assign stepSize = controlHi[10] ? 28'd4 : 28'd2;
  assign destReload = loadCnt && (destMode == INCRELOAD);

  assign srcNext = loadSad ? cutAddr(srcAddr[27:0], srcGamePak)
                           : cutAddr(stepAddr(srcReg, srcMode, stepSize), srcGamePak);
  assign destNext = (loadDad || destReload) ? cutAddr(destTarget[27:0], destGamePak)
                                            : cutAddr(stepAddr(destReg, destMode, stepSize),
                                                      destGamePak);

  always_ff @(posedge clk) begin
    if (loadSad || stepSrc) begin
      srcReg <= srcNext;
    end
    if (loadDad || stepDest || destReload) begin
      destReg <= destNext;
    end
    if (storeRData) begin
      chanData <= rdata; // word held for the write phase
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wordCnt <= '0;
    end else if (loadCnt) begin
      wordCnt <= '0;
    end else if (stepSrc) begin
      wordCnt <= wordCnt + 14'd1; // a zero count wraps at 16384
    end
  end

  assign xferDone = (wordCnt == controlLo[13:0]);
  assign chanAddr = {4'b0, writing ? destReg : srcReg};

endmodule

// ==== dmaBusArbiter.sv ====
// DMA memory bus arbiter
`timescale 1ns/1ns
`include "dma_defines.svh"

module dmaBusArbiter (
  input  logic [`DMA_CHANNELS-1:0]       busy,
  input  logic [`DMA_CHANNELS-1:0]       onBus,
  input  logic [`DMA_CHANNELS-1:0]       writing,
  input  logic [`DMA_CHANNELS-1:0][31:0] chanAddr,
  input  logic [`DMA_CHANNELS-1:0][31:0] chanData,
  input  logic [`DMA_CHANNELS-1:0]       wordSize,
  input  logic [`DMA_CHANNELS-1:0]       captureStop,
  input  logic [`DMA_CHANNELS-1:0]       seqDisable,
  output logic [`DMA_CHANNELS-1:0]       preempted,
  output logic [31:0]                    addr,
  output logic [31:0]                    wdata,
  output dma_pkg::busSize_t              size,
  output logic                           wen,
  output logic                           active,
  output logic [`DMA_CHANNELS-1:0]       disableDma
);
  import dma_pkg::*;

  // a channel yields to any busy channel of lower index
  always_comb begin : preemptChain
    logic chain;
    chain = 1'b0;
    for (int i = 0; i < `DMA_CHANNELS; i++) begin
      preempted[i] = chain;
      chain = chain | busy[i];
    end
  end

  // the sequencers keep at most one channel on the bus
  always_comb begin
    addr = '0;
    wdata = '0;
    size = HALF;
    wen = 1'b0;
    for (int i = `DMA_CHANNELS - 1; i >= 0; i--) begin
      if (onBus[i]) begin
        addr = chanAddr[i];
        wdata = chanData[i];
        size = wordSize[i] ? WORD : HALF;
        wen = writing[i];
      end
    end
  end

  assign active = |onBus;
  assign disableDma = seqDisable | captureStop; // block end or capture window end

endmodule

// ==== dmaTop.sv ====
// Four-channel DMA controller
`timescale 1ns/1ns
`include "dma_defines.svh"

module dmaTop (
  input  logic                           clk,
  input  logic                           rst_b,
  input  logic [`DMA_CHANNELS-1:0][15:0] controlLo,
  input  logic [`DMA_CHANNELS-1:0][15:0] controlHi,
  input  logic [`DMA_CHANNELS-1:0][31:0] srcAddr,
  input  logic [`DMA_CHANNELS-1:0][31:0] destAddr,
  input  logic [15:0]                    vcount,
  input  logic [15:0]                    hcount,
  input  logic                           soundReq,
  input  logic                           memWait,
  input  logic [31:0]                    rdata,
  output logic [31:0]                    addr,
  output logic [31:0]                    wdata,
  output dma_pkg::busSize_t              size,
  output logic                           wen,
  output logic                           active,
  output logic [`DMA_CHANNELS-1:0]       irq,
  output logic [`DMA_CHANNELS-1:0]       disableDma
);

  logic [`DMA_CHANNELS-1:0] busy;
  logic [`DMA_CHANNELS-1:0] onBus;
  logic [`DMA_CHANNELS-1:0] writing;
  logic [`DMA_CHANNELS-1:0] preempted;
  logic [`DMA_CHANNELS-1:0] wordSize;
  logic [`DMA_CHANNELS-1:0] captureStop;
  logic [`DMA_CHANNELS-1:0] seqDisable;
  logic [`DMA_CHANNELS-1:0][31:0] chanAddr;
  logic [`DMA_CHANNELS-1:0][31:0] chanData;

  for (genvar i = 0; i < `DMA_CHANNELS; i++) begin : gChan
    logic start;
    logic xferDone;
    logic loadCnt;
    logic loadSad;
    logic loadDad;
    logic stepSrc;
    logic stepDest;
    logic storeRData;

    assign wordSize[i] = controlHi[i][10];

    dmaStartTrigger #(.chanId(i)) startTrigger_i (
      .clk, .rst_b, .controlHi(controlHi[i]), .vcount, .hcount, .soundReq,
      .start, .captureStop(captureStop[i])
    );

    dmaSequencer sequencer_i (
      .clk, .rst_b, .controlHi(controlHi[i]), .start, .memWait,
      .preempted(preempted[i]), .xferDone,
      .loadCnt, .loadSad, .loadDad, .stepSrc, .stepDest, .storeRData,
      .busy(busy[i]), .onBus(onBus[i]), .writing(writing[i]),
      .irq(irq[i]), .disableDma(seqDisable[i])
    );

    dmaAddressPath #(.chanId(i)) addressPath_i (
      .clk, .rst_b, .controlLo(controlLo[i]), .controlHi(controlHi[i]),
      .srcAddr(srcAddr[i]), .destAddr(destAddr[i]), .rdata,
      .loadCnt, .loadSad, .loadDad, .stepSrc, .stepDest, .storeRData,
      .writing(writing[i]), .chanAddr(chanAddr[i]), .chanData(chanData[i]), .xferDone
    );
  end

  dmaBusArbiter busArbiter_i (
    .busy, .onBus, .writing, .chanAddr, .chanData, .wordSize, .captureStop, .seqDisable,
    .preempted, .addr, .wdata, .size, .wen, .active, .disableDma
  );

endmodule

// ==== dma_props.sv ====
// DMA bus arbiter assertions
`timescale 1ns/1ns
`include "dma_defines.svh"

module dmaProps (
  input logic                     clk,
  input logic                     rst_b,
  input logic [`DMA_CHANNELS-1:0] onBus,
  input logic [`DMA_CHANNELS-1:0] preempted,
  input logic [`DMA_CHANNELS-1:0] irq
);

  int failCount = 0; // failed assertions so far

  oneOwner: assert property (@(posedge clk) disable iff (!rst_b) $onehot0(onBus))
    else begin
      $error("more than one channel owns the memory bus");
      failCount++;
    end

  // a channel takes the bus only while no lower channel is busy
  for (genvar i = 0; i < `DMA_CHANNELS; i++) begin : gEntry
    busEntry: assert property (@(posedge clk) disable iff (!rst_b)
                               $rose(onBus[i]) |-> $past(!preempted[i]))
      else begin
        $error("channel %0d took the bus while preempted", i);
        failCount++;
      end
  end

  for (genvar i = 0; i < `DMA_CHANNELS; i++) begin : gIrq
    irqPulse: assert property (@(posedge clk) disable iff (!rst_b) irq[i] |=> !irq[i])
      else begin
        $error("irq %0d held for more than one cycle", i);
        failCount++;
      end
  end

endmodule

// sequencer and arbiter wires are all visible at the top level
bind dmaTop dmaProps props_i (.clk, .rst_b, .onBus, .preempted, .irq);

// ==== dmaTb.sv ====
// DMA controller testbench
`timescale 1ns/1ns
`include "dma_defines.svh"

module dmaTb;
  import dma_pkg::*;

  typedef struct packed {
    logic [1:0]  ch;
    logic [31:0] addr;
    logic [31:0] data;
    busSize_t    size;
  } busWrite_t;

  localparam int totalWords = 4 + 6 + 19 + 8 + 8 + 2;
  localparam int maxWait = 4;
  localparam int blankWaits = 600; // idle stretches between bursts
  localparam int rawLimit = 4 * (totalWords * 2 * maxWait + blankWaits);
  localparam int cycleLimit = (rawLimit > 20000) ? rawLimit : 20000;

  logic clk;
  logic rst_b;
  logic [`DMA_CHANNELS-1:0][15:0] controlLo;
  logic [`DMA_CHANNELS-1:0][15:0] controlHi;
  logic [`DMA_CHANNELS-1:0][31:0] srcAddr;
  logic [`DMA_CHANNELS-1:0][31:0] destAddr;
  logic [15:0] vcount;
  logic [15:0] hcount;
  logic soundReq;
  logic memWait;
  logic [31:0] rdata;
  logic [31:0] addr;
  logic [31:0] wdata;
  busSize_t size;
  logic wen;
  logic active;
  logic [`DMA_CHANNELS-1:0] irq;
  logic [`DMA_CHANNELS-1:0] disableDma;

  busWrite_t expQ[$];
  logic [31:0] dataSeed;
  logic waitOn = 1'b0;
  logic [`DMA_CHANNELS-1:0] irqSeen = '0;
  logic [`DMA_CHANNELS-1:0] disSeen = '0;
  logic [`DMA_CHANNELS-1:0] disPending = '0;
  int wrCnt[`DMA_CHANNELS] = '{default: 0};
  int ch2AtFirst = 0; // channel 2 write count at channel 0's first write
  int ch2AtLast = 0;
  int cycles = 0;

  dmaTop dmaTop_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] memPattern(input logic [31:0] a, input logic [31:0] seed);
    return (a * 32'h9E37_79B1) ^ seed;
  endfunction

  assign rdata = memPattern(addr, dataSeed); // memory read port

  function automatic logic [27:0] keepPak(input logic [27:0] a, input bit keep);
    logic [27:0] r;
    r = a;
    if (!keep) begin
      r[27] = 1'b0; // game-pak region not reachable
    end
    return r;
  endfunction

  function automatic logic [27:0] nextRef(input logic [27:0] a, input addrStep_t mode,
                                          input logic [27:0] step);
    case (mode)
      DEC:     return a - step;
      FIXED:   return a;
      default: return a + step;
    endcase
  endfunction

  // expected bus writes of one block; returns the source address after it
  function automatic logic [31:0] expectBlock(input int ch, input logic [15:0] hi,
                                              input logic [31:0] src, input logic [31:0] dst,
                                              input int words);
    busWrite_t e;
    addrStep_t srcMode;
    addrStep_t destMode;
    logic special;
    logic [31:0] base;
    logic [27:0] step;
    logic [27:0] s;
    logic [27:0] d;
    special = (hi[13:12] == 2'b11);
    step = hi[10] ? 28'd4 : 28'd2;
    srcMode = addrStep_t'(hi[8:7]);
    destMode = (special && (ch == 1 || ch == 2)) ? FIXED : addrStep_t'(hi[6:5]);
    base = (special && ch == 3) ? `CAPTURE_BASE : dst;
    s = keepPak(src[27:0], ch != 0);
    d = keepPak(base[27:0], ch == 3);
    for (int k = 0; k < words; k++) begin
      e.ch = 2'(ch);
      e.addr = {4'h0, d};
      e.data = memPattern({4'h0, s}, dataSeed);
      e.size = hi[10] ? WORD : HALF;
      expQ.push_back(e);
      s = keepPak(nextRef(s, srcMode, step), ch != 0);
      d = keepPak(nextRef(d, destMode, step), ch == 3);
    end
    return {4'h0, s};
  endfunction

  // enable and interrupt always set
  function automatic logic [15:0] ctrlWord(input startTiming_t t, input bit word, input bit rpt,
                                           input addrStep_t s, input addrStep_t d);
    return {1'b1, 1'b1, t, 1'b0, word, rpt, s, d, 5'b0};
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic checkBusWrite(input logic [31:0] addrGot, input logic [31:0] dataGot,
                               input busSize_t sizeGot, input logic [31:0] addrExp,
                               input logic [31:0] dataExp, input busSize_t sizeExp);
    if (addrGot !== addrExp || dataGot !== dataExp || sizeGot !== sizeExp) begin
      failRun($sformatf("ERROR at %0t: write %h/%h/%s, expected %h/%h/%s", $time, addrGot,
                        dataGot, sizeGot.name(), addrExp, dataExp, sizeExp.name()));
    end
  endtask

  task automatic checkIrq(input string what, input logic [`DMA_CHANNELS-1:0] got,
                          input logic [`DMA_CHANNELS-1:0] exp);
    if (got !== exp) begin
      failRun($sformatf("ERROR at %0t: %s channels %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic checkActive(input logic got, input logic exp);
    if (got !== exp) begin
      failRun($sformatf("ERROR at %0t: active %b, expected %b", $time, got, exp));
    end
  endtask

  task automatic checkDrained();
    if (expQ.size() != 0) begin
      failRun($sformatf("%0d expected bus writes never happened", expQ.size()));
    end
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic waitIrq(input int ch);
    while (!irqSeen[ch]) begin
      @(negedge clk);
    end
  endtask

  task automatic configure(input int ch, input logic [15:0] hi, input int words,
                           input logic [31:0] src, input logic [31:0] dst);
    @(negedge clk);
    controlLo[ch] = 16'(words);
    srcAddr[ch] = src;
    destAddr[ch] = dst;
    controlHi[ch] = hi;
  endtask

  always @(negedge clk) begin
    memWait <= waitOn && ($urandom % 3 == 0);
  end

  // host clears the enable bit after a disable pulse
  always @(negedge clk) begin
    for (int i = 0; i < `DMA_CHANNELS; i++) begin
      if (disPending[i]) begin
        controlHi[i][15] = 1'b0;
        disPending[i] = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      failRun($sformatf("timeout, the run passed %0d cycles", cycleLimit));
    end
  end

  // compare process matching each write to the head entry of its channel
  always @(posedge clk) begin
    int hit;
    int ch;
    logic [`DMA_CHANNELS-1:0] heads;
    if (dmaTop_i.props_i.failCount != 0) begin
      failRun("an arbiter assertion failed during the run");
    end
    if (rst_b) begin
      if ((irq & irqSeen) != '0) begin
        failRun("an irq bit pulsed twice within one block");
      end
      irqSeen = irqSeen | irq;
      disSeen = disSeen | disableDma;
      disPending = disPending | disableDma;
      if (wen) begin
        checkActive(active, 1'b1);
      end else if (expQ.size() == 0) begin
        checkActive(active, 1'b0); // no transfer pending
      end
      if (wen && !memWait) begin
        hit = -1;
        heads = '0;
        foreach (expQ[i]) begin
          if (hit < 0 && !heads[expQ[i].ch]) begin
            if (expQ[i].addr == addr) begin
              hit = i;
            end
            heads[expQ[i].ch] = 1'b1;
          end
        end
        if (expQ.size() == 0) begin
          failRun($sformatf("ERROR at %0t: unexpected write of %h to %h", $time, wdata, addr));
        end else begin
          if (hit < 0) begin
            hit = 0; // address unknown, report against the oldest entry
          end
          ch = int'(expQ[hit].ch);
          checkBusWrite(addr, wdata, size, expQ[hit].addr, expQ[hit].data, expQ[hit].size);
          if (ch == 0) begin
            if (ch2AtFirst < 0) begin
              ch2AtFirst = wrCnt[2];
            end
            ch2AtLast = wrCnt[2];
          end
          wrCnt[ch]++;
          expQ.delete(hit);
        end
      end
    end
  end

  initial begin
    logic [15:0] hi;
    logic [31:0] nextSrc;
    void'($urandom(75755));
    dataSeed = $urandom;
    rst_b = 1'b0;
    controlLo = '0;
    controlHi = '0;
    srcAddr = '0;
    destAddr = '0;
    vcount = '0;
    hcount = '0;
    soundReq = 1'b0;
    memWait = 1'b0;
    waitCycles(10);
    rst_b = 1'b1;
    waitCycles(2);

    // immediate word block on channel 0
    hi = ctrlWord(IMMEDIATE, 1'b1, 1'b0, INC, INC);
    void'(expectBlock(0, hi, 32'h0200_0100, 32'h0300_0000, 4));
    configure(0, hi, 4, 32'h0200_0100, 32'h0300_0000);
    waitIrq(0);
    checkDrained();
    waitCycles(4);
    checkIrq("irq", irqSeen, 4'b0001);
    checkIrq("disableDma", disSeen, 4'b0001);

    // halfwords on channel 3 under random wait states
    irqSeen = '0;
    disSeen = '0;
    hi = ctrlWord(IMMEDIATE, 1'b0, 1'b0, DEC, FIXED);
    void'(expectBlock(3, hi, 32'h0800_0200, 32'h0600_1000, 6));
    waitOn = 1'b1;
    configure(3, hi, 6, 32'h0800_0200, 32'h0600_1000);
    waitIrq(3);
    waitOn = 1'b0;
    checkDrained();
    waitCycles(4);
    checkIrq("irq", irqSeen, 4'b1000);

    // channel 0 cuts into a long channel 2 block
    irqSeen = '0;
    disSeen = '0;
    ch2AtFirst = -1;
    hi = ctrlWord(IMMEDIATE, 1'b1, 1'b0, INC, INC);
    void'(expectBlock(2, hi, 32'h0200_1000, 32'h0300_2000, 16));
    configure(2, hi, 16, 32'h0200_1000, 32'h0300_2000);
    while (wrCnt[2] < 4) begin
      @(negedge clk);
    end
    void'(expectBlock(0, hi, 32'h0200_4000, 32'h0300_4000, 3));
    configure(0, hi, 3, 32'h0200_4000, 32'h0300_4000);
    waitIrq(0);
    waitIrq(2);
    checkDrained();
    waitCycles(4);
    if (ch2AtFirst != ch2AtLast || ch2AtFirst <= 0 || ch2AtFirst >= 16) begin
      failRun("channel 0 writes were not nested between two channel 2 writes");
    end
    checkIrq("irq", irqSeen, 4'b0101);
    checkIrq("disableDma", disSeen, 4'b0101);

    // vertical blank bursts with repeat on channel 1
    hi = ctrlWord(VBLANK, 1'b1, 1'b1, INC, INCRELOAD);
    nextSrc = 32'h0200_8000;
    configure(1, hi, 4, nextSrc, 32'h0300_8000);
    waitCycles(30); // empty queue, any write here fails
    for (int b = 0; b < 2; b++) begin
      irqSeen = '0;
      nextSrc = expectBlock(1, hi, nextSrc, 32'h0300_8000, 4);
      vcount = 16'(`VBLANK_LINE);
      @(negedge clk);
      vcount = 16'(`VBLANK_LINE + 1);
      waitIrq(1);
      checkDrained();
      checkIrq("irq", irqSeen, 4'b0010);
      vcount = '0;
      waitCycles(20);
    end
    controlHi[1][15] = 1'b0;

    // sound requests on channel 2
    hi = ctrlWord(SPECIAL, 1'b1, 1'b1, INC, INC);
    nextSrc = 32'h0200_C000;
    configure(2, hi, 4, nextSrc, 32'h0400_00A0);
    waitCycles(10);
    for (int b = 0; b < 2; b++) begin
      irqSeen = '0;
      nextSrc = expectBlock(2, hi, nextSrc, 32'h0400_00A0, 4);
      soundReq = 1'b1;
      @(negedge clk);
      soundReq = 1'b0;
      waitIrq(2);
      checkDrained();
      checkIrq("irq", irqSeen, 4'b0100);
      waitCycles(10);
    end
    controlHi[2][15] = 1'b0;

    // video capture on channel 3, nothing moves before arming
    disSeen = '0;
    vcount = 16'd5;
    hi = ctrlWord(SPECIAL, 1'b1, 1'b1, INC, INC);
    configure(3, hi, 2, 32'h0200_E000, 32'h0300_E000);
    waitCycles(30);
    vcount = 16'(`CAPTURE_LAST);
    while (!disSeen[3]) begin
      @(negedge clk);
    end
    waitCycles(3);
    checkIrq("disableDma", disSeen, 4'b1000);
    irqSeen = '0;
    void'(expectBlock(3, hi, 32'h0200_E000, 32'h0300_E000, 2));
    controlHi[3][15] = 1'b1; // re-enable while armed
    waitCycles(3);
    vcount = 16'(`CAPTURE_FIRST);
    @(negedge clk);
    vcount = 16'd200;
    waitIrq(3);
    checkDrained();
    checkIrq("irq", irqSeen, 4'b1000);
    controlHi[3][15] = 1'b0;
    waitCycles(10);

    if (dmaTop_i.props_i.failCount != 0) begin
      failRun("an arbiter assertion failed during the run");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// ==== compile.f ====
+incdir+.
dma_pkg.sv
dmaStartTrigger.sv
dmaSequencer.sv
dmaAddressPath.sv
dmaBusArbiter.sv
dmaTop.sv
dma_props.sv
dmaTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dmaTb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
